// File: logic/ctr_pkg.sv
/*
  Shared types and constants of the CTR counter unit.
  Sparse codes other than SP2V_HIGH and SP2V_LOW are treated as faults.
*/
package ctr_pkg;

  //////////////////////////////
  // Sparse two-valued signals
  //////////////////////////////

  // One bit per rail
  localparam int Sp2VWidth = 3;

  typedef enum logic [Sp2VWidth-1:0] {
    SP2V_HIGH = 3'b011,
    SP2V_LOW  = 3'b100
  } sp2v_e;

  // Rail polarity, bit set means active-high rail
  localparam logic [Sp2VWidth-1:0] SP2V_LOGIC_HIGH = 3'b011;

  // Invalid enable code driven after a fault
  // Register treats it as a lock and refuses loads
  localparam logic [Sp2VWidth-1:0] SP2V_LOCK = 3'b000;

  //////////////////////////////
  // Counter geometry
  //////////////////////////////

  localparam int NumBytes      = 16;
  localparam int NumSlices     = 8;
  localparam int SliceSize     = 16;
  localparam int SliceIdxWidth = 3;

  // Block order, byte 0 is the most significant byte
  typedef logic [NumBytes-1:0][7:0] ctr_block_t;

  //////////////////////////////
  // Rail FSM
  //////////////////////////////

  localparam int CtrStateWidth = 6;

  // Codes keep a Hamming distance of at least 3
  typedef enum logic [CtrStateWidth-1:0] {
    CTR_IDLE  = 6'b010110,
    CTR_INCR  = 6'b101101,
    CTR_ERROR = 6'b001011
  } ctr_fsm_e;

  // Multi-bit rail outputs, OR-combined and compared in ctr_incr
  typedef struct packed {
    logic [SliceIdxWidth-1:0] slice_idx;
    logic [SliceSize-1:0]     slice;
    logic                     alert;
  } rail_out_t;

endpackage

// File: logic/ctr_sel_chk.sv
/*
  Registers a sparse control input, one cycle of latency.
  Invalid codes are forwarded as SP2V_LOW together with err_o.
*/
`timescale 1ns/100ps

module ctr_sel_chk import ctr_pkg::*; (
  input  logic  clk_i,
  input  logic  arst_n_i,
  input  sp2v_e sel_i,
  output sp2v_e sel_o,
  output logic  err_o
);

  sp2v_e sel_d;
  logic  err_d;

  // Only the two legal codes pass through
  always_comb begin : check_code
    case (sel_i)
      SP2V_HIGH, SP2V_LOW: begin
        sel_d = sel_i;
        err_d = 1'b0;
      end
      default: begin
        // Fault, force the inactive value
        sel_d = SP2V_LOW;
        err_d = 1'b1;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin : sel_reg
    if (!arst_n_i) begin
      sel_o <= SP2V_LOW;
      err_o <= 1'b0;
    end else begin
      sel_o <= sel_d;
      err_o <= err_d;
    end
  end

endmodule

// File: logic/ctr_fsm_rail.sv
/*
  One rail of the redundant slice-increment FSM.
  ActiveHigh = 0 inverts request, ready and write enable at the ports.
  CTR_ERROR is left only through reset.
*/
`timescale 1ns/100ps

module ctr_fsm_rail import ctr_pkg::*; #(
  parameter bit ActiveHigh = 1'b1
) (
  input  logic                 clk_i,
  input  logic                 arst_n_i,

  input  logic                 incr_i,
  input  logic                 incr_err_i,
  input  logic                 mr_err_i,
  input  logic [SliceSize-1:0] slice_i,

  output logic                 ready_o,
  output logic                 we_o,
  output rail_out_t            rail_o
);

  ctr_fsm_e                 state_q;
  ctr_fsm_e                 state_d;
  logic [SliceIdxWidth-1:0] idx_q;
  logic [SliceIdxWidth-1:0] idx_d;
  logic                     carry_q;
  logic                     carry_d;
  logic                     was_idle_q;

  logic                     incr;
  logic                     ready;
  logic                     we;
  logic                     alert;
  logic                     carry_out;
  logic [SliceSize-1:0]     slice_sum;

  // Polarity at the input
  assign incr = ActiveHigh ? incr_i : ~incr_i;

  // Slice adder, carry out ends or continues the walk
  assign {carry_out, slice_sum} = {1'b0, slice_i} + {{SliceSize{1'b0}}, carry_q};

  //////////////////////////////
  // Next state
  //////////////////////////////

  always_comb begin : fsm_comb
    state_d = state_q;
    idx_d   = idx_q;
    carry_d = carry_q;
    ready   = 1'b0;
    we      = 1'b0;
    alert   = 1'b0;

    case (state_q)
      CTR_IDLE: begin
        ready = 1'b1;
        // Request must have been sampled while ready was high
        if (incr && was_idle_q) begin
          state_d = CTR_INCR;
          idx_d   = '0;
          carry_d = 1'b1;
        end
      end

      CTR_INCR: begin
        we      = 1'b1;
        carry_d = carry_out;
        if (carry_out && (idx_q != SliceIdxWidth'(NumSlices - 1))) begin
          // Carry survives, next slice up
          idx_d = idx_q + SliceIdxWidth'(1);
        end else begin
          state_d = CTR_IDLE;
          idx_d   = '0;
        end
      end

      CTR_ERROR: begin
        alert = 1'b1;
      end

      default: begin
        // Corrupted state register
        alert   = 1'b1;
        state_d = CTR_ERROR;
      end
    endcase

    // Faults from outside the rail override everything
    if (incr_err_i || mr_err_i) begin
      state_d = CTR_ERROR;
    end
    if (mr_err_i) begin
      we = 1'b0;
    end
  end

  //////////////////////////////
  // State registers
  //////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin : fsm_reg
    if (!arst_n_i) begin
      state_q    <= CTR_IDLE;
      idx_q      <= '0;
      carry_q    <= 1'b0;
      was_idle_q <= 1'b1;
    end else begin
      state_q    <= state_d;
      idx_q      <= idx_d;
      carry_q    <= carry_d;
      // Ready as seen by the request register
      was_idle_q <= (state_q == CTR_IDLE);
    end
  end

  // Polarity at the outputs
  assign ready_o = ActiveHigh ? ready : ~ready;
  assign we_o    = ActiveHigh ? we : ~we;

  assign rail_o = '{slice_idx: idx_q, slice: slice_sum, alert: alert};

endmodule

// File: logic/ctr_incr.sv
/*
  Sliced incrementer, one 16-bit slice per clock from the least significant end.
  Three redundant rails, any disagreement or invalid request is terminal.
  After a fault all slice enables carry the lock code.
*/
`timescale 1ns/100ps

module ctr_incr import ctr_pkg::*; (
  input  logic                  clk_i,
  input  logic                  arst_n_i,

  input  sp2v_e                 incr_i,
  input  logic                  incr_err_i,
  output sp2v_e                 ready_o,
  output logic                  alert_o,

  input  ctr_block_t            ctr_i,
  output ctr_block_t            ctr_o,
  output sp2v_e [NumSlices-1:0] ctr_we_o
);

  // Block order to numeric order and back
  function automatic ctr_block_t rev_bytes(input ctr_block_t blk);
    ctr_block_t rev;
    for (int b = 0; b < NumBytes; b++) begin
      rev[b] = blk[NumBytes-1-b];
    end
    return rev;
  endfunction

  ctr_block_t                          ctr_i_rev;
  logic [NumSlices-1:0][SliceSize-1:0] ctr_i_sl;
  logic [NumSlices-1:0][SliceSize-1:0] ctr_o_sl;
  logic [SliceSize-1:0]                sel_slice;

  // One bit per rail
  logic [Sp2VWidth-1:0]                sp_incr;
  logic [Sp2VWidth-1:0]                sp_ready;
  logic [Sp2VWidth-1:0]                sp_we;

  rail_out_t                           rail_out [Sp2VWidth];
  rail_out_t                           comb;
  logic                                mr_err;

  sp2v_e                               ctr_we;
  sp2v_e                               idle_we;
  sp2v_e [NumSlices-1:0]               we_rev;

  //////////////////////////////
  // Inputs
  //////////////////////////////

  assign ctr_i_rev = rev_bytes(ctr_i);
  assign ctr_i_sl  = ctr_i_rev;

  // Slice the rails point at
  assign sel_slice = ctr_i_sl[comb.slice_idx];

  assign sp_incr = incr_i;

  //////////////////////////////
  // Redundant rails
  //////////////////////////////

  for (genvar r = 0; r < Sp2VWidth; r++) begin : gen_rail
    ctr_fsm_rail #(
      .ActiveHigh ( SP2V_LOGIC_HIGH[r] )
    ) u_rail (
      .clk_i      ( clk_i       ),
      .arst_n_i   ( arst_n_i    ),
      .incr_i     ( sp_incr[r]  ),
      .incr_err_i ( incr_err_i  ),
      .mr_err_i   ( mr_err      ),
      .slice_i    ( sel_slice   ),
      .ready_o    ( sp_ready[r] ),
      .we_o       ( sp_we[r]    ),
      .rail_o     ( rail_out[r] )
    );
  end

  // OR-combine, then every rail must equal the result
  always_comb begin : combine_rails
    comb   = '0;
    mr_err = 1'b0;
    for (int r = 0; r < Sp2VWidth; r++) begin
      comb = rail_out_t'(comb | rail_out[r]);
    end
    for (int r = 0; r < Sp2VWidth; r++) begin
      if (rail_out[r] != comb) begin
        mr_err = 1'b1;
      end
    end
  end

  assign ready_o = sp2v_e'(sp_ready);
  assign alert_o = comb.alert;

  // Lock code replaces the rail enables once alerted
  assign ctr_we  = comb.alert ? sp2v_e'(SP2V_LOCK) : sp2v_e'(sp_we);
  assign idle_we = comb.alert ? sp2v_e'(SP2V_LOCK) : SP2V_LOW;

  //////////////////////////////
  // Outputs
  //////////////////////////////

  // New slice into the numeric-order block
  always_comb begin : insert_slice
    ctr_o_sl                 = ctr_i_sl;
    ctr_o_sl[comb.slice_idx] = comb.slice;
  end

  assign ctr_o = rev_bytes(ctr_block_t'(ctr_o_sl));

  // Enable at the selected slice only
  always_comb begin : place_we
    for (int s = 0; s < NumSlices; s++) begin
      we_rev[s] = (SliceIdxWidth'(s) == comb.slice_idx) ? ctr_we : idle_we;
    end
  end

  // Slice order back to block order
  always_comb begin : rev_we
    for (int s = 0; s < NumSlices; s++) begin
      ctr_we_o[s] = we_rev[NumSlices-1-s];
    end
  end

endmodule

// File: logic/ctr_iv_reg.sv
/*
  128-bit counter register, cleared by reset.
  Load is taken only while every slice enable is SP2V_LOW.
*/
`timescale 1ns/100ps

module ctr_iv_reg import ctr_pkg::*; (
  input  logic                  clk_i,
  input  logic                  arst_n_i,

  input  logic                  load_i,
  input  ctr_block_t            load_data_i,

  input  ctr_block_t            ctr_next_i,
  input  sp2v_e [NumSlices-1:0] ctr_we_i,

  output ctr_block_t            ctr_o
);

  logic [NumSlices-1:0][SliceSize-1:0] ctr_q;
  logic [NumSlices-1:0][SliceSize-1:0] next_sl;
  logic                                we_any;
  logic                                we_idle;

  assign next_sl = ctr_next_i;

  // Slice write in progress, or lock code present
  always_comb begin : we_scan
    we_any  = 1'b0;
    we_idle = 1'b1;
    for (int s = 0; s < NumSlices; s++) begin
      if (ctr_we_i[s] == SP2V_HIGH) begin
        we_any = 1'b1;
      end
      if (ctr_we_i[s] != SP2V_LOW) begin
        we_idle = 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin : ctr_reg
    if (!arst_n_i) begin
      ctr_q <= '0;
    end else if (we_any) begin
      // Invalid codes write nothing
      for (int s = 0; s < NumSlices; s++) begin
        if (ctr_we_i[s] == SP2V_HIGH) begin
          ctr_q[s] <= next_sl[s];
        end
      end
    end else if (load_i && we_idle) begin
      ctr_q <= load_data_i;
    end
  end

  assign ctr_o = ctr_q;

endmodule

// File: logic/ctr_unit.sv
/*
  CTR counter unit top level.
  incr_i is taken while ready_o is SP2V_HIGH, one increment per request pulse.
  alert_o stays high until reset, the counter is frozen meanwhile.
*/
`timescale 1ns/100ps

module ctr_unit import ctr_pkg::*; (
  input  logic       clk_i,
  input  logic       arst_n_i,

  // Whole-block load
  input  logic       load_i,
  input  ctr_block_t load_data_i,

  // Increment handshake
  input  sp2v_e      incr_i,
  output sp2v_e      ready_o,
  output logic       alert_o,

  output ctr_block_t ctr_o
);

  sp2v_e                 incr;
  logic                  incr_err;
  ctr_block_t            ctr_next;
  sp2v_e [NumSlices-1:0] ctr_we;

  // Request register and code check
  ctr_sel_chk u_incr_chk (
    .clk_i    ( clk_i    ),
    .arst_n_i ( arst_n_i ),
    .sel_i    ( incr_i   ),
    .sel_o    ( incr     ),
    .err_o    ( incr_err )
  );

  ctr_incr u_incr (
    .clk_i      ( clk_i    ),
    .arst_n_i   ( arst_n_i ),
    .incr_i     ( incr     ),
    .incr_err_i ( incr_err ),
    .ready_o    ( ready_o  ),
    .alert_o    ( alert_o  ),
    .ctr_i      ( ctr_o    ),
    .ctr_o      ( ctr_next ),
    .ctr_we_o   ( ctr_we   )
  );

  ctr_iv_reg u_iv_reg (
    .clk_i       ( clk_i       ),
    .arst_n_i    ( arst_n_i    ),
    .load_i      ( load_i      ),
    .load_data_i ( load_data_i ),
    .ctr_next_i  ( ctr_next    ),
    .ctr_we_i    ( ctr_we      ),
    .ctr_o       ( ctr_o       )
  );

endmodule

// File: sim/ctr_unit_properties.sv
/*
  Concurrent checks on the ctr_unit handshake, alert and slice enables.
  All checks are idle while reset is asserted.
*/
`timescale 1ns/100ps

module ctr_unit_properties import ctr_pkg::*; (
  input logic                  clk_i,
  input logic                  arst_n_i,
  input sp2v_e                 ready_i,
  input logic                  alert_i,
  input sp2v_e [NumSlices-1:0] ctr_we_i
);

  // One bit per slice, set for an active write
  logic [NumSlices-1:0] we_high;

  // Failed assertions so far, read by the testbench
  int fail_count = 0;

  always_comb begin : we_decode
    for (int s = 0; s < NumSlices; s++) begin
      we_high[s] = (ctr_we_i[s] == SP2V_HIGH);
    end
  end

  // Only the two legal codes on ready_o
  ready_legal: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (ready_i == SP2V_HIGH) || (ready_i == SP2V_LOW))
    else begin
      $error("ready_o holds a code other than HIGH or LOW");
      fail_count++;
    end

  // Idle unit writes nothing
  no_write_when_ready: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (ready_i == SP2V_HIGH) |-> (we_high == '0))
    else begin
      $error("slice write while ready_o is HIGH");
      fail_count++;
    end

  // Walk touches one slice per cycle
  one_slice_at_a_time: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $onehot0(we_high))
    else begin
      $error("more than one slice enable active");
      fail_count++;
    end

  // Terminal error state
  alert_sticky: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    alert_i |=> alert_i)
    else begin
      $error("alert_o dropped without a reset");
      fail_count++;
    end

endmodule

// File: sim/ctr_unit_tb.sv
/*
  Testbench for ctr_unit, clock period 8 ns, inputs driven 1 ns after the rising edge.
  Expected counter values come from a 128-bit add on the byte-reversed block.
*/
`timescale 1ns/100ps

module ctr_unit_tb import ctr_pkg::*; ();

  localparam int WaitLimit = 20;

  logic       clk_i = 1'b0;
  logic       arst_n_i;
  logic       load_i;
  ctr_block_t load_data_i;
  sp2v_e      incr_i;
  sp2v_e      ready_o;
  logic       alert_o;
  ctr_block_t ctr_o;

  logic [31:0] lcg_state;
  int          checks;
  int          errors;
  int          tests;

  always #4 clk_i = ~clk_i;

  ctr_unit dut_i (.*);

  // Property checker on every ctr_unit
  bind ctr_unit ctr_unit_properties u_props (
    .clk_i    ( clk_i    ),
    .arst_n_i ( arst_n_i ),
    .ready_i  ( ready_o  ),
    .alert_i  ( alert_o  ),
    .ctr_we_i ( ctr_we   )
  );

  //////////////////////////////
  // Model and random data
  //////////////////////////////

  function automatic logic [127:0] rand_num();
    logic [127:0] v;
    for (int w = 0; w < 4; w++) begin
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      v[32*w +: 32] = lcg_state;
    end
    return v;
  endfunction

  // Byte 0 of the block is the top byte of the number
  function automatic logic [127:0] to_num(input ctr_block_t blk);
    logic [127:0] num;
    for (int b = 0; b < 16; b++) begin
      num[8*(15-b) +: 8] = blk[b];
    end
    return num;
  endfunction

  function automatic ctr_block_t to_blk(input logic [127:0] num);
    ctr_block_t blk;
    for (int b = 0; b < 16; b++) begin
      blk[b] = num[8*(15-b) +: 8];
    end
    return blk;
  endfunction

  // Random number whose n lowest slices are all ones, slice n is not
  function automatic ctr_block_t chain_blk(input int n);
    logic [127:0] num;
    num = rand_num();
    for (int s = 0; s < n; s++) begin
      num[16*s +: 16] = 16'hffff;
    end
    if (n < 8 && num[16*n +: 16] == 16'hffff) begin
      num[16*n] = 1'b0;
    end
    return to_blk(num);
  endfunction

  //////////////////////////////
  // Checks and drivers
  //////////////////////////////

  // Procedural failures plus failed properties
  function automatic int fail_total();
    return errors + dut_i.u_props.fail_count;
  endfunction

  task automatic check_block(input ctr_block_t got, input ctr_block_t exp, input string what);
    checks++;
    assert (got == exp) else begin
      errors++;
      $display("FAIL %0d ns: %s, ctr_o %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_cond(input bit ok, input string what);
    checks++;
    assert (ok) else begin
      errors++;
      $display("FAIL %0d ns: %s", $time, what);
    end
  endtask

  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  task automatic apply_reset();
    arst_n_i = 1'b0;
    load_i   = 1'b0;
    incr_i   = SP2V_LOW;
    repeat (3) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;
  endtask

  task automatic load_block(input ctr_block_t blk);
    load_i      = 1'b1;
    load_data_i = blk;
    next_cycle();
    load_i = 1'b0;
    check_block(ctr_o, blk, "load");
  endtask

  task automatic check_reset_state();
    check_cond(ready_o == SP2V_HIGH, "ready_o not HIGH after reset");
    check_cond(!alert_o, "alert_o set after reset");
    check_block(ctr_o, '0, "reset value");
    load_block(to_blk(rand_num()));
  endtask

  // One request pulse, busy cycles counted at edge plus 1 ns
  task automatic run_incr(input ctr_block_t start, input bit load_busy, input string what);
    logic [127:0] num;
    int           k_exp;
    int           n;
    int           busy;
    load_block(start);
    num   = to_num(start);
    k_exp = 1;
    while (k_exp < 8 && num[16*(k_exp-1) +: 16] == 16'hffff) begin
      k_exp++;
    end
    incr_i = SP2V_HIGH;
    next_cycle();
    incr_i = SP2V_LOW;
    n = 0;
    while (ready_o != SP2V_LOW && n < WaitLimit) begin
      next_cycle();
      n++;
    end
    check_cond(n < WaitLimit, {what, ": ready_o never went LOW after the request"});
    busy = 0;
    while (ready_o == SP2V_LOW && busy < WaitLimit) begin
      busy++;
      // Load during the walk, must be dropped
      load_i      = load_busy && (busy == 1);
      load_data_i = to_blk(rand_num());
      next_cycle();
    end
    load_i = 1'b0;
    check_cond(busy < WaitLimit, {what, ": ready_o never came back HIGH"});
    check_cond(busy == k_exp, {what, ": wrong number of busy cycles"});
    check_block(ctr_o, to_blk(num + 128'd1), what);
  endtask

  task automatic report(input int first_err, input string name);
    tests++;
    $display("test %0d %s: %s", tests, name, (fail_total() == first_err) ? "ok" : "failed");
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin : run
    ctr_block_t frozen;
    int         e;
    int         n;
    arst_n_i    = 1'b0;
    load_i      = 1'b0;
    load_data_i = '0;
    incr_i      = SP2V_LOW;
    lcg_state   = 32'd43;
    checks      = 0;
    errors      = 0;
    tests       = 0;
    apply_reset();

    e = fail_total();
    check_reset_state();
    report(e, "reset and load");

    e = fail_total();
    for (int i = 0; i < 6; i++) begin
      run_incr(chain_blk(0), 1'b0, "single slice");
    end
    report(e, "single slice increment");

    e = fail_total();
    for (int c = 1; c < 8; c++) begin
      run_incr(chain_blk(c), 1'b0, "carry chain");
    end
    report(e, "carry chains");

    e = fail_total();
    run_incr(chain_blk(8), 1'b0, "wrap");
    check_block(ctr_o, '0, "wrap to zero");
    report(e, "wrap");

    e = fail_total();
    run_incr(chain_blk(0), 1'b1, "load while busy");
    run_incr(chain_blk(3), 1'b1, "load while busy");
    report(e, "load while busy");

    // Invalid request code, then the unit stays locked
    e = fail_total();
    frozen = chain_blk(2);
    load_block(frozen);
    incr_i = sp2v_e'(3'b111);
    next_cycle();
    incr_i = SP2V_LOW;
    n = 0;
    while (!alert_o && n < WaitLimit) begin
      next_cycle();
      n++;
    end
    check_cond(alert_o, "alert_o never rose after an invalid request code");
    check_cond(ready_o == SP2V_LOW, "ready_o not LOW in the error state");
    incr_i      = SP2V_HIGH;
    load_i      = 1'b1;
    load_data_i = to_blk(rand_num());
    next_cycle();
    incr_i = SP2V_LOW;
    load_i = 1'b0;
    repeat (10) next_cycle();
    check_cond(alert_o && ready_o == SP2V_LOW, "unit left the error state");
    check_block(ctr_o, frozen, "frozen counter");
    apply_reset();
    check_reset_state();
    report(e, "invalid request code");

    $display("tests %0d, checks %0d, failures %0d", tests, checks, fail_total());
    if (fail_total() == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: ctr_unit.f
logic/ctr_pkg.sv
logic/ctr_sel_chk.sv
logic/ctr_fsm_rail.sv
logic/ctr_incr.sv
logic/ctr_iv_reg.sv
logic/ctr_unit.sv
sim/ctr_unit_properties.sv
sim/ctr_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the ctr_unit testbench with Verilator
# Exit status is 0 only when the log holds the pass line and no failure line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module ctr_unit_tb -f ctr_unit.f \
  -Mdir obj_dir -o sim_ctr_unit > build.log 2>&1 || { cat build.log; exit 1; }

./obj_dir/sim_ctr_unit > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
cat sim.log

grep -q "Simulation FAILED" sim.log && exit 1
grep -q "Simulation PASSED" sim.log || exit 1
exit 0
